//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // privilege of a fetch
  typedef enum logic [1:0] {
    user_mode       = 2'b00,
    supervisor_mode = 2'b01,
    machine_mode    = 2'b11
  } priv_mode_t;

  // core side request into the fetch buffer
  typedef struct packed {
    logic       valid;
    logic       fence;
    logic       spec;
    priv_mode_t mode;
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } fetch_rsp_t;

  // word aligned prefetch request towards the sram
  typedef struct packed {
    logic        valid;
    priv_mode_t  mode;
    logic [31:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } imem_rsp_t;

  // program load, target 0 is the sram, 1 is the limit register
  typedef struct packed {
    logic        valid;
    logic        target;
    logic [29:0] addr;
    logic [31:0] data;
  } load_req_t;

endpackage

`default_nettype wire

//--- src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // fixed index width, only the low depth bits are used
  localparam int buffer_addr_bits = 8;

  typedef struct packed {
    logic        error;
    logic        filled;
    logic [29:0] tag;
    logic [31:0] word;
  } buffer_entry_t;

  typedef struct packed {
    logic                        wen;
    logic [buffer_addr_bits-1:0] waddr;
    buffer_entry_t               entry;
  } buffer_write_t;

  typedef struct packed {
    logic [buffer_addr_bits-1:0] raddr1;
    logic [buffer_addr_bits-1:0] raddr2;
  } buffer_read_t;

  typedef struct packed {
    buffer_entry_t rdata1;
    buffer_entry_t rdata2;
  } buffer_data_t;

  typedef enum logic {
    run_state,
    flush_state
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/fetch_buffer_array.sv
`default_nettype none

module fetch_buffer_array #(
  parameter int depth_log2 = 3
) (
  input  logic                    clock,
  input  fetch_pkg::buffer_write_t write,
  input  fetch_pkg::buffer_read_t  read,
  output fetch_pkg::buffer_data_t  data
);

  localparam int depth = 2 ** depth_log2;

  fetch_pkg::buffer_entry_t entries [depth];

  always_ff @(posedge clock) begin
    if (write.wen) begin
      entries[write.waddr[depth_log2-1:0]] <= write.entry;
    end
  end

  // two read ports so a straddling instruction sees both words at once
  assign data.rdata1 = entries[read.raddr1[depth_log2-1:0]];
  assign data.rdata2 = entries[read.raddr2[depth_log2-1:0]];

endmodule

`default_nettype wire

//--- src/fetch_buffer_ctrl.sv
`default_nettype none

module fetch_buffer_ctrl #(
  parameter int depth_log2 = 3
) (
  input  logic                     clock,
  input  logic                     reset,
  input  mem_pkg::fetch_req_t      fetch_req,
  output mem_pkg::fetch_rsp_t      fetch_rsp,
  output mem_pkg::imem_req_t       imem_req,
  input  mem_pkg::imem_rsp_t       imem_rsp,
  output fetch_pkg::buffer_write_t write,
  output fetch_pkg::buffer_read_t  read,
  input  fetch_pkg::buffer_data_t  data
);

  localparam int depth = 2 ** depth_log2;
  localparam int count_bits = depth_log2 + 1;
  // run-ahead limit in halfwords, capacity minus two words
  localparam logic [count_bits-1:0] max_count = count_bits'(2 * depth - 4);

  fetch_pkg::ctrl_state_t   state_q;
  fetch_pkg::ctrl_state_t   state_d;
  logic [depth_log2-1:0]    sweep_q;
  logic [depth_log2-1:0]    sweep_d;
  logic [31:0]              pf_addr_q;
  logic [31:0]              pf_addr_d;
  mem_pkg::priv_mode_t      pf_mode_q;
  mem_pkg::priv_mode_t      pf_mode_d;
  logic [count_bits-1:0]    count_q;
  logic [count_bits-1:0]    count_d;
  logic                     stop_q;
  logic                     started_q;
  logic [31:0]              rsp_addr_q;

  logic                     lookup;
  logic                     redirect;
  logic                     fence_start;
  logic [31:0]              next_addr;
  fetch_pkg::buffer_entry_t rsp_entry;
  fetch_pkg::buffer_entry_t first;
  fetch_pkg::buffer_entry_t second;
  logic                     first_hit;
  logic                     second_hit;
  logic [15:0]              half;
  logic                     compressed;
  logic                     rsp_ready;
  logic                     rsp_error;
  logic [31:0]              rsp_rdata;
  logic [count_bits-1:0]    step;
  logic [count_bits-1:0]    base_count;
  logic [31:0]              base_addr;
  mem_pkg::priv_mode_t      base_mode;
  logic                     base_stop;
  logic                     issue;

  assign redirect    = fetch_req.valid && fetch_req.spec && !fetch_req.fence;
  assign fence_start = fetch_req.valid && fetch_req.fence && state_q == fetch_pkg::run_state;
  assign lookup      = fetch_req.valid && !fetch_req.spec && !fetch_req.fence &&
                       state_q == fetch_pkg::run_state;
  assign next_addr   = fetch_req.addr + 32'd4;

  assign rsp_entry = '{
    error:  imem_rsp.error,
    filled: 1'b1,
    tag:    rsp_addr_q[31:2],
    word:   imem_rsp.rdata
  };

  always_comb begin
    read = '0;
    read.raddr1[depth_log2-1:0] = fetch_req.addr[depth_log2+1:2];
    read.raddr2[depth_log2-1:0] = next_addr[depth_log2+1:2];
  end

  // fence sweep has priority over the sram response
  always_comb begin
    write = '0;
    if (fence_start) begin
      write.wen = 1'b1;
    end else if (state_q == fetch_pkg::flush_state) begin
      write.wen = 1'b1;
      write.waddr[depth_log2-1:0] = sweep_q;
    end else if (imem_rsp.ready) begin
      write.wen = 1'b1;
      write.waddr[depth_log2-1:0] = rsp_addr_q[depth_log2+1:2];
      write.entry = rsp_entry;
    end
  end

  // tag match, a word written this cycle also counts
  always_comb begin
    if (write.wen && write.entry.filled && write.entry.tag == fetch_req.addr[31:2]) begin
      first = write.entry;
      first_hit = 1'b1;
    end else begin
      first = data.rdata1;
      first_hit = data.rdata1.filled && data.rdata1.tag == fetch_req.addr[31:2];
    end
    if (write.wen && write.entry.filled && write.entry.tag == next_addr[31:2]) begin
      second = write.entry;
      second_hit = 1'b1;
    end else begin
      second = data.rdata2;
      second_hit = data.rdata2.filled && data.rdata2.tag == next_addr[31:2];
    end
  end

  assign half       = fetch_req.addr[1] ? first.word[31:16] : first.word[15:0];
  assign compressed = half[1:0] != 2'b11;
  assign step       = compressed ? count_bits'(1) : count_bits'(2);

  always_comb begin
    rsp_ready = 1'b0;
    rsp_error = 1'b0;
    rsp_rdata = '0;
    if (lookup) begin
      if (compressed || !fetch_req.addr[1] || first.error) begin
        rsp_ready = first_hit;
        rsp_error = first_hit && first.error;
        rsp_rdata = compressed ? {16'h0000, half} : first.word;
      end else begin
        // upper half of this word joined with the lower half of the next
        rsp_ready = first_hit && second_hit;
        rsp_error = first_hit && second_hit && second.error;
        rsp_rdata = {second.word[15:0], half};
      end
      if (rsp_error) begin
        rsp_rdata = '0;
      end
    end
  end

  assign fetch_rsp = '{ready: rsp_ready, error: rsp_error, rdata: rsp_rdata};

  always_comb begin
    base_addr = pf_addr_q;
    base_mode = pf_mode_q;
    base_count = count_q;
    base_stop = stop_q || (imem_rsp.ready && imem_rsp.error);
    if (rsp_ready && !rsp_error) begin
      base_count = (count_q >= step) ? count_q - step : '0;
    end
    // restart from the aligned word, an odd halfword start is never consumed
    if (fence_start || redirect) begin
      base_addr = {fetch_req.addr[31:2], 2'b00};
      base_mode = fetch_req.mode;
      base_count = '0;
      base_count[0] = fetch_req.addr[1];
      base_stop = 1'b0;
    end
    issue = started_q && state_q == fetch_pkg::run_state && !fence_start &&
            !base_stop && base_count < max_count;
    pf_addr_d = issue ? base_addr + 32'd4 : base_addr;
    pf_mode_d = base_mode;
    count_d = issue ? base_count + count_bits'(2) : base_count;
  end

  assign imem_req = '{valid: issue, mode: base_mode, addr: base_addr};

  always_comb begin
    state_d = state_q;
    sweep_d = sweep_q;
    case (state_q)
      fetch_pkg::run_state: begin
        if (fence_start) begin
          state_d = fetch_pkg::flush_state;
          sweep_d = depth_log2'(1);
        end
      end
      fetch_pkg::flush_state: begin
        sweep_d = sweep_q + depth_log2'(1);
        if (sweep_q == depth_log2'(depth - 1)) begin
          state_d = fetch_pkg::run_state;
          sweep_d = '0;
        end
      end
      default: begin
        state_d = fetch_pkg::run_state;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= fetch_pkg::run_state;
      sweep_q <= '0;
      pf_addr_q <= '0;
      pf_mode_q <= mem_pkg::machine_mode;
      count_q <= '0;
      stop_q <= 1'b0;
      started_q <= 1'b0;
    end else begin
      state_q <= state_d;
      sweep_q <= sweep_d;
      pf_addr_q <= pf_addr_d;
      pf_mode_q <= pf_mode_d;
      count_q <= count_d;
      stop_q <= base_stop;
      started_q <= 1'b1;
    end
  end

  // address of the word the sram returns next cycle
  always_ff @(posedge clock) begin
    if (issue) begin
      rsp_addr_q <= base_addr;
    end
  end

endmodule

`default_nettype wire

//--- src/instr_sram.sv
`default_nettype none

module instr_sram #(
  parameter int imem_words_log2 = 10
) (
  input  logic                clock,
  input  logic                reset,
  input  mem_pkg::load_req_t  load_req,
  input  mem_pkg::imem_req_t  imem_req,
  output mem_pkg::imem_rsp_t  imem_rsp,
  output logic [31:0]         check_addr,
  output mem_pkg::priv_mode_t check_mode,
  input  logic                fault
);

  localparam int words = 2 ** imem_words_log2;

  logic [31:0]         mem [words];
  logic                req_valid_q;
  logic [31:0]         req_addr_q;
  mem_pkg::priv_mode_t req_mode_q;

  // program load port
  always_ff @(posedge clock) begin
    if (load_req.valid && !load_req.target) begin
      mem[load_req.addr[imem_words_log2-1:0]] <= load_req.data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= imem_req.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (imem_req.valid) begin
      req_addr_q <= imem_req.addr;
      req_mode_q <= imem_req.mode;
    end
  end

  // limit check runs on the registered request
  assign check_addr = req_addr_q;
  assign check_mode = req_mode_q;

  assign imem_rsp = '{
    ready: req_valid_q,
    error: req_valid_q && fault,
    rdata: mem[req_addr_q[imem_words_log2+1:2]]
  };

endmodule

`default_nettype wire

//--- src/fetch_limit_reg.sv
`default_nettype none

module fetch_limit_reg (
  input  logic                clock,
  input  logic                reset,
  input  mem_pkg::load_req_t  load_req,
  input  logic [31:0]         addr,
  input  mem_pkg::priv_mode_t mode,
  output logic                fault
);

  logic [31:0] limit_q;

  // all ones, nothing faults after reset
  always_ff @(posedge clock) begin
    if (reset) begin
      limit_q <= '1;
    end else if (load_req.valid && load_req.target) begin
      limit_q <= load_req.data;
    end
  end

  // machine mode fetches are never limited
  assign fault = mode != mem_pkg::machine_mode && addr >= limit_q;

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`default_nettype none

module fetch_unit #(
  parameter int depth_log2      = 3,
  parameter int imem_words_log2 = 10
) (
  input  logic                clock,
  input  logic                reset,
  input  mem_pkg::fetch_req_t fetch_req,
  output mem_pkg::fetch_rsp_t fetch_rsp,
  input  mem_pkg::load_req_t  load_req
);

  mem_pkg::imem_req_t       imem_req;
  mem_pkg::imem_rsp_t       imem_rsp;
  fetch_pkg::buffer_write_t buffer_write;
  fetch_pkg::buffer_read_t  buffer_read;
  fetch_pkg::buffer_data_t  buffer_data;
  logic [31:0]              check_addr;
  mem_pkg::priv_mode_t      check_mode;
  logic                     fault;

  fetch_buffer_ctrl #(
    .depth_log2 (depth_log2)
  ) u_fetch_buffer_ctrl (
    .clock     (clock),
    .reset     (reset),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .imem_req  (imem_req),
    .imem_rsp  (imem_rsp),
    .write     (buffer_write),
    .read      (buffer_read),
    .data      (buffer_data)
  );

  fetch_buffer_array #(
    .depth_log2 (depth_log2)
  ) u_fetch_buffer_array (
    .clock (clock),
    .write (buffer_write),
    .read  (buffer_read),
    .data  (buffer_data)
  );

  instr_sram #(
    .imem_words_log2 (imem_words_log2)
  ) u_instr_sram (
    .clock      (clock),
    .reset      (reset),
    .load_req   (load_req),
    .imem_req   (imem_req),
    .imem_rsp   (imem_rsp),
    .check_addr (check_addr),
    .check_mode (check_mode),
    .fault      (fault)
  );

  fetch_limit_reg u_fetch_limit_reg (
    .clock    (clock),
    .reset    (reset),
    .load_req (load_req),
    .addr     (check_addr),
    .mode     (check_mode),
    .fault    (fault)
  );

endmodule

`default_nettype wire

//--- tests/fetch_unit_tb.sv
`default_nettype none

module fetch_unit_tb;

  localparam int depth_log2 = 3;
  localparam int imem_words_log2 = 10;
  localparam int depth = 2 ** depth_log2;
  localparam int reset_cycles = 4;
  localparam int max_tries = 64;
  localparam int random_streams = 30;
  // directed fetches plus at most six per random stream
  localparam int planned_fetches = 31 + random_streams * 6;
  localparam int watchdog_cycles = reset_cycles + planned_fetches * max_tries;

  logic                clock;
  logic                reset;
  mem_pkg::fetch_req_t fetch_req;
  mem_pkg::fetch_rsp_t fetch_rsp;
  mem_pkg::load_req_t  load_req;

  // shadow of the program image, first 256 words only
  logic [31:0]         shadow_mem [256];
  logic [31:0]         shadow_limit;
  mem_pkg::priv_mode_t shadow_mode;
  logic                rsp_seen;
  logic [32:0]         expected_rsp;
  int                  check_count = 0;
  int                  error_count = 0;
  int                  missing_count = 0;

  fetch_unit #(
    .depth_log2      (depth_log2),
    .imem_words_log2 (imem_words_log2)
  ) u_fetch_unit (
    .clock     (clock),
    .reset     (reset),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .load_req  (load_req)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // expected {error, rdata} for one fetch
  function automatic logic [32:0] predict_fetch(input logic [31:0] addr,
                                                input mem_pkg::priv_mode_t mode);
    logic [31:0] word_addr;
    logic [31:0] word0;
    logic [31:0] word1;
    logic [15:0] half;
    logic        fault0;
    logic        fault1;
    logic        error;
    logic [31:0] rdata;
    word_addr = {addr[31:2], 2'b00};
    word0 = shadow_mem[word_addr[9:2]];
    word1 = shadow_mem[word_addr[9:2] + 8'd1];
    fault0 = mode != mem_pkg::machine_mode && word_addr >= shadow_limit;
    fault1 = mode != mem_pkg::machine_mode && (word_addr + 32'd4) >= shadow_limit;
    half = addr[1] ? word0[31:16] : word0[15:0];
    if (half[1:0] != 2'b11) begin
      error = fault0;
      rdata = {16'h0000, half};
    end else if (!addr[1]) begin
      error = fault0;
      rdata = word0;
    end else begin
      // straddles into the next word
      error = fault0 || fault1;
      rdata = {word1[15:0], half};
    end
    if (error) begin
      rdata = '0;
    end
    return {error, rdata};
  endfunction

  function automatic logic [31:0] instr_bytes(input logic [31:0] addr);
    logic [31:0] word;
    logic [15:0] half;
    word = shadow_mem[addr[9:2]];
    half = addr[1] ? word[31:16] : word[15:0];
    return (half[1:0] == 2'b11) ? 32'd4 : 32'd2;
  endfunction

  function automatic mem_pkg::priv_mode_t random_mode();
    logic [1:0] pick;
    pick = 2'($urandom % 4);
    case (pick)
      2'd2: return mem_pkg::user_mode;
      2'd3: return mem_pkg::supervisor_mode;
      default: return mem_pkg::machine_mode;
    endcase
  endfunction

  // compare every lookup that comes back ready
  always @(negedge clock) begin
    rsp_seen = 1'b0;
    if (!reset && fetch_req.valid && !fetch_req.spec && !fetch_req.fence && fetch_rsp.ready) begin
      rsp_seen = 1'b1;
      expected_rsp = predict_fetch(fetch_req.addr, shadow_mode);
      check_count++;
      assert (fetch_rsp.error == expected_rsp[32] && fetch_rsp.rdata == expected_rsp[31:0])
      else begin
        error_count++;
        $display("ERROR %0t: fetch at %h gave error %0b data %h, expected error %0b data %h",
                 $time, fetch_req.addr, fetch_rsp.error, fetch_rsp.rdata,
                 expected_rsp[32], expected_rsp[31:0]);
      end
    end else if (!reset && fetch_req.valid && (fetch_req.spec || fetch_req.fence)) begin
      // redirects and fences get no answer
      check_count++;
      assert (!fetch_rsp.ready)
      else begin
        error_count++;
        $display("ERROR %0t: redirect or fence at %h was answered with ready",
                 $time, fetch_req.addr);
      end
    end
  end

  task automatic apply_inputs(input mem_pkg::fetch_req_t req, input mem_pkg::load_req_t load);
    @(posedge clock);
    #1;
    fetch_req = req;
    load_req = load;
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) apply_inputs('0, '0);
  endtask

  task automatic write_load(input logic target, input logic [29:0] index, input logic [31:0] data);
    mem_pkg::load_req_t load;
    load = '0;
    load.valid = 1'b1;
    load.target = target;
    load.addr = index;
    load.data = data;
    apply_inputs('0, load);
    if (target) begin
      shadow_limit = data;
    end else begin
      shadow_mem[index[7:0]] = data;
    end
  endtask

  task automatic redirect_to(input logic [31:0] addr, input mem_pkg::priv_mode_t mode);
    mem_pkg::fetch_req_t req;
    req = '0;
    req.valid = 1'b1;
    req.spec = 1'b1;
    req.mode = mode;
    req.addr = addr;
    apply_inputs(req, '0);
    shadow_mode = mode;
  endtask

  // sweep takes one cycle per entry
  task automatic fence_buffer(input logic [31:0] addr, input mem_pkg::priv_mode_t mode);
    mem_pkg::fetch_req_t req;
    req = '0;
    req.valid = 1'b1;
    req.fence = 1'b1;
    req.mode = mode;
    req.addr = addr;
    apply_inputs(req, '0);
    shadow_mode = mode;
    idle_cycles(depth);
  endtask

  task automatic fetch_once(input logic [31:0] addr);
    mem_pkg::fetch_req_t req;
    int                  tries;
    logic                got;
    req = '0;
    req.valid = 1'b1;
    req.mode = shadow_mode;
    req.addr = addr;
    tries = 0;
    got = 1'b0;
    while (!got && tries < max_tries) begin
      apply_inputs(req, '0);
      @(negedge clock);
      #1;
      got = rsp_seen;
      tries++;
    end
    if (!got) begin
      missing_count++;
      $display("no response for the fetch at address %h after %0d tries", addr, max_tries);
    end
  endtask

  // prefetch stops after a fault, so the stream ends there too
  task automatic run_stream(input logic [31:0] start, input mem_pkg::priv_mode_t mode,
                            input int count);
    logic [31:0] addr;
    logic [32:0] expect_now;
    logic        stop;
    int          done_count;
    redirect_to(start, mode);
    addr = start;
    stop = 1'b0;
    done_count = 0;
    while (!stop && done_count < count) begin
      fetch_once(addr);
      expect_now = predict_fetch(addr, mode);
      stop = expect_now[32];
      addr = addr + instr_bytes(addr);
      done_count++;
    end
    idle_cycles(1);
  endtask

  task automatic check_limit_side(input mem_pkg::priv_mode_t mode);
    fence_buffer(32'h0000_02f8, mode);
    run_stream(32'h0000_02f8, mode, 1);
    run_stream(32'h0000_02fc, mode, 1);
    run_stream(32'h0000_02fe, mode, 1);
    run_stream(32'h0000_0300, mode, 1);
    run_stream(32'h0000_0304, mode, 1);
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0]         word;
    logic [31:0]         pick;
    mem_pkg::priv_mode_t mode;
    int                  len;
    void'($urandom(32'h642eb539));
    reset = 1'b1;
    fetch_req = '0;
    load_req = '0;
    shadow_mode = mem_pkg::machine_mode;
    shadow_limit = '1;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;

    // random image, roughly half the halfwords are 32-bit starts
    for (int i = 0; i < 256; i++) begin
      word = $urandom;
      if ($urandom % 2 == 0) word[1:0] = 2'b11;
      if ($urandom % 2 == 0) word[17:16] = 2'b11;
      if (i >= 64 && i < 76) word[1:0] = 2'b11;
      write_load(1'b0, 30'(i), word);
    end
    write_load(1'b0, 30'd128, 32'h8e12_4a55);
    write_load(1'b0, 30'd132, 32'hb0a3_1100);
    write_load(1'b0, 30'd133, 32'h0452_c3d7);
    fence_buffer(32'h0, mem_pkg::machine_mode);

    run_stream(32'h0000_0100, mem_pkg::machine_mode, 12);
    run_stream(32'h0000_0200, mem_pkg::machine_mode, 2);
    run_stream(32'h0000_0210, mem_pkg::machine_mode, 3);

    // old words sit in the buffer before the rewrite
    run_stream(32'h0000_0100, mem_pkg::machine_mode, 2);
    // new program words must not come from stale entries
    write_load(1'b0, 30'd64, ~shadow_mem[64] | 32'h3);
    write_load(1'b0, 30'd65, ~shadow_mem[65] | 32'h3);
    fence_buffer(32'h0000_0100, mem_pkg::machine_mode);
    run_stream(32'h0000_0100, mem_pkg::machine_mode, 2);

    write_load(1'b1, 30'd0, 32'h0000_0300);
    check_limit_side(mem_pkg::user_mode);
    check_limit_side(mem_pkg::machine_mode);

    for (int s = 0; s < random_streams; s++) begin
      mode = random_mode();
      pick = $urandom % 480;
      len = int'(1 + $urandom % 6);
      // buffer entries keep the error flag of the mode that filled them
      if (mode != shadow_mode || $urandom % 5 == 0) begin
        fence_buffer({pick[30:0], 1'b0}, mode);
      end
      run_stream({pick[30:0], 1'b0}, mode, len);
    end

    $display("checks %0d, wrong values %0d, missing responses %0d",
             check_count, error_count, missing_count);
    if (error_count == 0 && missing_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_unit.f
src/mem_pkg.sv
src/fetch_pkg.sv
src/fetch_buffer_array.sv
src/fetch_buffer_ctrl.sv
src/instr_sram.sv
src/fetch_limit_reg.sv
src/fetch_unit.sv
tests/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module fetch_unit_tb \
  -f fetch_unit.f \
  -o fetch_unit_sim

./obj_dir/fetch_unit_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
